/* hw/cpuPkg.sv */
package cpuPkg;

	//**************************************************************************
	// Sequencer and datapath encodings
	//**************************************************************************

	typedef enum logic [4:0] {
		stFetch, stDecode, stMov, stMvi0, stMvi1, stAlu0, stAlu1, stUnary,
		stLxi0, stLxi1, stDirect0, stDirect1, stDirect2, stJmp0, stJmp1, stHalt
	} cpuState;

	// The first eight follow the 8080 ALU field order
	typedef enum logic [3:0] {
		aluAdd, aluAdc, aluSub, aluSbb, aluAnd, aluXor, aluOr, aluCmp,
		aluStc, aluCmc, aluCma, aluPass
	} aluOp;

	typedef enum logic [4:0] {
		dbNone = 5'b00000,
		dbAlu  = 5'b00001, // Source is the ALU result, destination the ALU input latch
		dbPsr  = 5'b00010,
		dbAll  = 5'b00011,
		dbAlh  = 5'b00100,
		dbSpl  = 5'b00101,
		dbSph  = 5'b00110,
		dbB    = 5'b01000, // B to A are {2'b01, register field}
		dbC    = 5'b01001,
		dbD    = 5'b01010,
		dbE    = 5'b01011,
		dbH    = 5'b01100,
		dbL    = 5'b01101,
		dbM    = 5'b01110,
		dbA    = 5'b01111
	} busSel;

	typedef enum logic [1:0] {
		addrPc,
		addrHl,
		addrAl
	} addrSel;

	//**************************************************************************
	// Instruction register and inter-module structs
	//**************************************************************************

	typedef struct packed {
		logic [1:0] group;
		logic [2:0] dst;
		logic [2:0] src;
	} opcodeRegs;

	typedef struct packed {
		logic [1:0] group;
		logic [1:0] pair;
		logic       q;
		logic [2:0] low;
	} opcodePairs;

	typedef union packed {
		opcodeRegs  regs;
		opcodePairs pairs;
	} opcode;

	typedef struct packed {
		logic        read;
		logic        write;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} memReq;

	typedef struct packed {
		logic       advance;
		logic       irLoad;
		logic       pcIncrement;
		logic       pcJump;
		logic       alIncrement;
		busSel      dbSrc;
		busSel      dbDst;
		addrSel     addr;
		aluOp       aluFn;
		logic [7:0] flagWrite; // PSR bits taken from the ALU flags
	} ctrlWord;

	localparam int FLAG_C = 0;
	localparam int FLAG_P = 2;
	localparam int FLAG_Z = 6;
	localparam int FLAG_S = 7;

	localparam logic [7:0] PSR_RESET = 8'h02;

endpackage

/* hw/cpuAlu.sv */
module cpuAlu import cpuPkg::*; (
	input  opcode      ir,
	input  aluOp       op,
	input  logic [7:0] accumulator,
	input  logic [7:0] aluIn,
	input  logic [7:0] psr,
	output logic [7:0] aluOut,
	output logic [7:0] flags,
	output logic       cond
);

	logic carryIn;
	logic carryOut;

	assign carryIn = psr[FLAG_C] & (op == aluAdc || op == aluSbb);

	always_comb begin
		carryOut = psr[FLAG_C];
		aluOut = aluIn;
		case (op)
			aluAdd, aluAdc: {carryOut, aluOut} = accumulator + aluIn + 9'(carryIn);
			aluSub, aluSbb, aluCmp: begin
				{carryOut, aluOut} = accumulator - aluIn - 9'(carryIn); // Bit 8 is the borrow
			end
			aluAnd: begin
				aluOut = accumulator & aluIn;
				carryOut = 1'b0;
			end
			aluXor: begin
				aluOut = accumulator ^ aluIn;
				carryOut = 1'b0;
			end
			aluOr: begin
				aluOut = accumulator | aluIn;
				carryOut = 1'b0;
			end
			aluStc: begin
				aluOut = accumulator;
				carryOut = 1'b1;
			end
			aluCmc: begin
				aluOut = accumulator;
				carryOut = ~psr[FLAG_C];
			end
			aluCma: aluOut = ~accumulator;
			default: aluOut = aluIn;
		endcase
	end

	always_comb begin
		flags = 8'h00;
		flags[FLAG_S] = aluOut[7];
		flags[FLAG_Z] = aluOut == 8'h00;
		flags[FLAG_P] = ~^aluOut; // Set on even parity
		flags[FLAG_C] = carryOut;
	end

	// Jump condition from the middle field of the opcode
	always_comb begin
		case (ir.regs.dst)
			3'd0: cond = !psr[FLAG_Z];
			3'd1: cond = psr[FLAG_Z];
			3'd2: cond = !psr[FLAG_C];
			3'd3: cond = psr[FLAG_C];
			3'd4: cond = !psr[FLAG_P];
			3'd5: cond = psr[FLAG_P];
			3'd6: cond = !psr[FLAG_S];
			default: cond = psr[FLAG_S];
		endcase
	end

endmodule

/* hw/cpuControl.sv */
module cpuControl import cpuPkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  opcode   ir,
	input  logic    cond,
	input  logic    memDone,
	output ctrlWord ctrl,
	output memReq   memStrobe,
	output logic    halted
);

	localparam logic [7:0] arithFlags = 8'((1 << FLAG_S) | (1 << FLAG_Z) | (1 << FLAG_P) |
		(1 << FLAG_C));
	localparam logic [7:0] carryFlag = 8'(1 << FLAG_C);

	cpuState state;
	cpuState nextState;
	cpuState decodeGoto;

	//**************************************************************************
	// Instruction decode
	//**************************************************************************

	logic isHalt, isMov, isAlu, isAluI, isMvi, isLxi, isLda, isSta, isUnary, isJmp, isJmpCc;
	logic memSrc, memDst;
	busSel srcReg, dstReg, pairDst;

	assign isHalt = ir == 8'h76;
	assign isMov = ir.regs.group == 2'b01 && !isHalt;
	assign isAlu = ir.regs.group == 2'b10;
	assign isAluI = ir.regs.group == 2'b11 && ir.regs.src == 3'b110;
	assign isMvi = ir.regs.group == 2'b00 && ir.regs.src == 3'b110;
	assign isLxi = ir.pairs.group == 2'b00 && !ir.pairs.q && ir.pairs.low == 3'b001;
	assign isLda = ir == 8'h3A;
	assign isSta = ir == 8'h32;
	assign isUnary = ir == 8'h2F || ir == 8'h37 || ir == 8'h3F; // CMA, STC, CMC
	assign isJmp = ir == 8'hC3;
	assign isJmpCc = ir.regs.group == 2'b11 && ir.regs.src == 3'b010;

	assign memSrc = ir.regs.src == 3'b110;
	assign memDst = ir.regs.dst == 3'b110;
	assign srcReg = busSel'({2'b01, ir.regs.src});
	assign dstReg = busSel'({2'b01, ir.regs.dst});

	// Low byte goes to C, E or L first, SP has its own endpoints
	always_comb begin
		if (ir.pairs.pair == 2'b11)
			pairDst = state == stLxi0 ? dbSpl : dbSph;
		else
			pairDst = busSel'({2'b01, ir.pairs.pair, state == stLxi0});
	end

	always_comb begin
		if (isHalt)
			decodeGoto = stHalt;
		else if (isMov)
			decodeGoto = stMov;
		else if (isAlu || isAluI)
			decodeGoto = stAlu0;
		else if (isMvi)
			decodeGoto = stMvi0;
		else if (isLxi)
			decodeGoto = stLxi0;
		else if (isLda || isSta)
			decodeGoto = stDirect0;
		else if (isUnary)
			decodeGoto = stUnary;
		else if (isJmp || isJmpCc)
			decodeGoto = stJmp0;
		else
			decodeGoto = stFetch; // NOP and everything not implemented
	end

	//**************************************************************************
	// Sequencer
	//**************************************************************************

	always_comb begin
		case (state)
			stFetch: nextState = stDecode;
			stDecode: nextState = decodeGoto;
			stMvi0: nextState = memDst ? stMvi1 : stFetch;
			stAlu0: nextState = stAlu1;
			stLxi0: nextState = stLxi1;
			stDirect0: nextState = stDirect1;
			stDirect1: nextState = stDirect2;
			stJmp0: nextState = stJmp1;
			stHalt: nextState = stHalt;
			default: nextState = stFetch;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= stFetch;
		end else if (ctrl.advance) begin
			state <= nextState;
		end
	end

	assign halted = state == stHalt;

	always_comb begin
		ctrl = '0;
		ctrl.aluFn = aluPass;
		memStrobe = '0;
		case (state)
			stFetch: begin
				memStrobe.read = 1'b1;
				ctrl.irLoad = 1'b1;
				ctrl.pcIncrement = 1'b1;
			end
			stMov: begin
				ctrl.addr = addrHl;
				ctrl.dbSrc = srcReg;
				ctrl.dbDst = dstReg;
				memStrobe.read = memSrc;
				memStrobe.write = memDst;
			end
			stMvi0: begin
				memStrobe.read = 1'b1;
				ctrl.pcIncrement = 1'b1;
				ctrl.dbSrc = dbM;
				ctrl.dbDst = memDst ? dbAlu : dstReg; // Park the byte for the write to M
			end
			stMvi1: begin
				memStrobe.write = 1'b1;
				ctrl.addr = addrHl;
				ctrl.dbSrc = dbAlu;
			end
			stAlu0: begin
				ctrl.dbDst = dbAlu;
				if (isAluI) begin
					memStrobe.read = 1'b1;
					ctrl.pcIncrement = 1'b1;
					ctrl.dbSrc = dbM;
				end else begin
					memStrobe.read = memSrc;
					ctrl.addr = addrHl;
					ctrl.dbSrc = srcReg;
				end
			end
			stAlu1: begin
				ctrl.aluFn = aluOp'({1'b0, ir.regs.dst});
				ctrl.flagWrite = arithFlags;
				ctrl.dbSrc = dbAlu;
				ctrl.dbDst = ir.regs.dst == 3'b111 ? dbNone : dbA; // CMP keeps A
			end
			stUnary: begin
				ctrl.dbSrc = dbAlu;
				ctrl.dbDst = dbA;
				case (ir.regs.dst)
					3'b101: ctrl.aluFn = aluCma;
					3'b110: begin
						ctrl.aluFn = aluStc;
						ctrl.flagWrite = carryFlag;
					end
					default: begin
						ctrl.aluFn = aluCmc;
						ctrl.flagWrite = carryFlag;
					end
				endcase
			end
			stLxi0, stLxi1: begin
				memStrobe.read = 1'b1;
				ctrl.pcIncrement = 1'b1;
				ctrl.dbSrc = dbM;
				ctrl.dbDst = pairDst;
			end
			stDirect0, stDirect1, stJmp0: begin
				memStrobe.read = 1'b1;
				ctrl.pcIncrement = 1'b1;
				ctrl.dbSrc = dbM;
				ctrl.dbDst = state == stDirect1 ? dbAlh : dbAll;
			end
			stDirect2: begin
				ctrl.addr = addrAl;
				ctrl.alIncrement = 1'b1;
				if (isLda) begin
					memStrobe.read = 1'b1;
					ctrl.dbSrc = dbM;
					ctrl.dbDst = dbA;
				end else begin
					memStrobe.write = 1'b1;
					ctrl.dbSrc = dbA;
				end
			end
			stJmp1: begin
				memStrobe.read = 1'b1;
				ctrl.dbSrc = dbM;
				ctrl.dbDst = dbAlh;
				ctrl.pcJump = isJmp || cond;
				ctrl.pcIncrement = isJmpCc && !cond; // Step over the high address byte
			end
			default: ;
		endcase
		ctrl.advance = !(memStrobe.read || memStrobe.write) || memDone;
	end

endmodule

/* hw/cpuDatapath.sv */
module cpuDatapath import cpuPkg::*; #(
	parameter logic [15:0] resetPc = 16'h0000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  ctrlWord     ctrl,
	input  logic [7:0]  memRdata,
	input  logic [7:0]  aluOut,
	input  logic [7:0]  flags,
	output opcode       ir,
	output logic [7:0]  psr,
	output logic [7:0]  accumulator,
	output logic [7:0]  aluIn,
	output logic [15:0] memAddr,
	output logic [7:0]  memWdata
);

	localparam logic [7:0] flagBits = 8'((1 << FLAG_S) | (1 << FLAG_Z) | (1 << FLAG_P) |
		(1 << FLAG_C));

	logic [7:0] regB, regC, regD, regE, regH, regL;
	logic [15:0] sp;
	logic [15:0] pc;
	logic [15:0] al;
	logic [15:0] alNext;
	logic [7:0] dataBus;
	logic [7:0] psrNext;

	//**************************************************************************
	// Internal data bus
	//**************************************************************************

	always_comb begin
		case (ctrl.dbSrc)
			dbB: dataBus = regB;
			dbC: dataBus = regC;
			dbD: dataBus = regD;
			dbE: dataBus = regE;
			dbH: dataBus = regH;
			dbL: dataBus = regL;
			dbM: dataBus = memRdata;
			dbA: dataBus = accumulator;
			dbAlu: dataBus = aluOut;
			dbSpl: dataBus = sp[7:0];
			dbSph: dataBus = sp[15:8];
			default: dataBus = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{accumulator, regB, regC, regD, regE, regH, regL} <= '0;
			aluIn <= '0;
			sp <= '0;
		end else if (ctrl.advance) begin
			case (ctrl.dbDst)
				dbB: regB <= dataBus;
				dbC: regC <= dataBus;
				dbD: regD <= dataBus;
				dbE: regE <= dataBus;
				dbH: regH <= dataBus;
				dbL: regL <= dataBus;
				dbA: accumulator <= dataBus;
				dbAlu: aluIn <= dataBus;
				dbSpl: sp[7:0] <= dataBus;
				dbSph: sp[15:8] <= dataBus;
				default: ; // M goes out on the write data, the rest have no register here
			endcase
		end
	end

	//**************************************************************************
	// Address latch, PC and instruction register
	//**************************************************************************

	// A jump takes the latch value including the byte arriving this step
	always_comb begin
		alNext = al;
		if (ctrl.dbDst == dbAll)
			alNext[7:0] = dataBus;
		if (ctrl.dbDst == dbAlh)
			alNext[15:8] = dataBus;
		if (ctrl.alIncrement)
			alNext = al + 16'd1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= resetPc;
			al <= '0;
			ir <= '0;
		end else if (ctrl.advance) begin
			al <= alNext;
			if (ctrl.pcJump)
				pc <= alNext;
			else if (ctrl.pcIncrement)
				pc <= pc + 16'd1;
			if (ctrl.irLoad)
				ir <= memRdata;
		end
	end

	assign psrNext = (psr & ~ctrl.flagWrite) | (flags & ctrl.flagWrite);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			psr <= PSR_RESET;
		end else if (ctrl.advance) begin
			psr <= (psrNext & flagBits) | PSR_RESET; // Bit 1 reads 1, bits 3 to 5 read 0
		end
	end

	always_comb begin
		case (ctrl.addr)
			addrHl: memAddr = {regH, regL};
			addrAl: memAddr = al;
			default: memAddr = pc;
		endcase
	end

	assign memWdata = dataBus;

endmodule

/* hw/cpuTop.sv */
module cpuTop import cpuPkg::*; #(
	parameter logic [15:0] resetPc = 16'h0000
) (
	input  logic       clk,
	input  logic       rst_n,
	output memReq      mem,
	input  logic [7:0] memRdata,
	input  logic       memDone,
	output logic       halted
);

	ctrlWord ctrl;
	memReq memStrobe;
	opcode ir;
	logic [7:0] psr;
	logic [7:0] accumulator;
	logic [7:0] aluIn;
	logic [7:0] aluOut;
	logic [7:0] flags;
	logic cond;
	logic [15:0] memAddr;
	logic [7:0] memWdata;

	cpuControl control_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ir       (ir),
		.cond     (cond),
		.memDone  (memDone),
		.ctrl     (ctrl),
		.memStrobe(memStrobe),
		.halted   (halted)
	);

	cpuDatapath #(
		.resetPc(resetPc)
	) datapath_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.memRdata   (memRdata),
		.aluOut     (aluOut),
		.flags      (flags),
		.ir         (ir),
		.psr        (psr),
		.accumulator(accumulator),
		.aluIn      (aluIn),
		.memAddr    (memAddr),
		.memWdata   (memWdata)
	);

	cpuAlu alu_i (
		.ir         (ir),
		.op         (ctrl.aluFn),
		.accumulator(accumulator),
		.aluIn      (aluIn),
		.psr        (psr),
		.aluOut     (aluOut),
		.flags      (flags),
		.cond       (cond)
	);

	// Strobes come from the sequencer, address and data from the datapath
	always_comb begin
		mem = memStrobe;
		mem.addr = memAddr;
		mem.wdata = memWdata;
	end

endmodule

/* verif/cpuTb.sv */
module cpuTb import cpuPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [15:0] resetPc = 16'h0100;
	localparam int unsigned randSeed = 32'h32949f63;
	localparam int numBlocks = 27; // Three passes over the eight conditions and JMP
	localparam int overheadNs = 1000; // Reset, the check after HLT and some slack

	logic clk;
	logic rst_n;
	memReq mem;
	logic [7:0] memRdata;
	logic memDone;
	logic halted;

	logic [7:0] memory [0:65535];
	logic [7:0] refMem [0:65535];
	logic [15:0] emitPc;
	logic [15:0] storeAddr;
	int numInstr;
	logic imageReady = 1'b0;

	logic pending;
	int waitLeft;
	memReq heldReq;

	cpuTop #(
		.resetPc(resetPc)
	) dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.mem     (mem),
		.memRdata(memRdata),
		.memDone (memDone),
		.halted  (halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic checkEqual(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	function automatic logic [7:0] fillByte(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h5A;
	endfunction

	//**************************************************************************
	// Program image
	//**************************************************************************

	task automatic putByte(input logic [7:0] b);
		memory[emitPc] = b;
		emitPc = emitPc + 16'd1;
	endtask

	task automatic putOp(input logic [7:0] op);
		putByte(op);
		numInstr++;
	endtask

	task automatic putOpImm8(input logic [7:0] op, input logic [7:0] imm);
		putOp(op);
		putByte(imm);
	endtask

	task automatic putOpImm16(input logic [7:0] op, input logic [15:0] imm);
		putOp(op);
		putByte(imm[7:0]);
		putByte(imm[15:8]);
	endtask

	task automatic putStore();
		putOpImm16(8'h32, storeAddr); // STA to the next result slot
		storeAddr = storeAddr + 16'd1;
	endtask

	// B, C, D, E or A, so that HL keeps pointing into the data area
	function automatic logic [2:0] pickDataReg();
		logic [2:0] idx;
		idx = 3'($urandom_range(4, 0));
		return idx == 3'd4 ? 3'd7 : idx;
	endfunction

	function automatic logic [2:0] pickSrcReg();
		logic [2:0] idx;
		idx = 3'($urandom_range(6, 0));
		return idx == 3'd6 ? 3'd7 : idx;
	endfunction

	task automatic buildProgram();
		int aluSel;
		int cc;
		emitPc = resetPc;
		numInstr = 0;
		storeAddr = 16'h9000;
		putOpImm16(8'h01, 16'($urandom));
		putOpImm16(8'h11, 16'($urandom));
		putOpImm16(8'h31, 16'($urandom));
		putOpImm16(8'h21, {8'h80, 8'($urandom)});
		putOpImm8(8'h3E, 8'($urandom));
		for (int blk = 0; blk < numBlocks; blk++) begin
			case ($urandom_range(3, 0))
				0: begin
					putOpImm8({2'b00, pickDataReg(), 3'b110}, 8'($urandom));
					putOpImm8(8'h36, 8'($urandom)); // MVI M
				end
				1: begin
					putOp({2'b01, pickDataReg(), pickSrcReg()});
					putOp({2'b01, 3'd6, pickSrcReg()}); // MOV M,r
				end
				2: begin
					putOpImm16(8'h21, {8'h80, 8'($urandom)});
					putOp({2'b01, pickDataReg(), 3'd6}); // MOV r,M
				end
				default: begin
					putOpImm16(8'h3A, {8'hA0, 8'($urandom)});
					putStore();
				end
			endcase
			aluSel = int'($urandom_range(10, 0));
			if (aluSel < 8) begin
				if ($urandom_range(1, 0) == 1)
					putOp({2'b10, aluSel[2:0], 3'($urandom_range(7, 0))});
				else
					putOpImm8({2'b11, aluSel[2:0], 3'b110}, 8'($urandom));
			end else begin
				putOp(aluSel == 8 ? 8'h37 : (aluSel == 9 ? 8'h3F : 8'h2F));
			end
			putStore();
			// A taken jump skips the marker store, so the slot keeps its fill byte
			cc = blk % 9;
			putOpImm8(8'h3E, fillByte(storeAddr) ^ 8'hFF);
			putOpImm16(cc == 8 ? 8'hC3 : {2'b11, cc[2:0], 3'b010}, emitPc + 16'd6);
			putStore();
		end
		for (int r = 0; r < 6; r++) begin
			putOp({2'b01, 3'd7, 3'(r)});
			putStore();
		end
		putOp(8'h76);
	endtask

	//**************************************************************************
	// Reference interpreter
	//**************************************************************************

	function automatic logic evenParity(input logic [7:0] v);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++)
			ones = ones + int'(v[i]);
		return (ones % 2) == 0;
	endfunction

	function automatic logic conditionHolds(input logic [2:0] cc, input logic fs,
		input logic fz, input logic fp, input logic fc);
		case (cc)
			3'd0: return !fz;
			3'd1: return fz;
			3'd2: return !fc;
			3'd3: return fc;
			3'd4: return !fp;
			3'd5: return fp;
			3'd6: return !fs;
			default: return fs;
		endcase
	endfunction

	function automatic logic runReference();
		logic [7:0] r [0:7];
		logic [15:0] pc;
		logic [15:0] hl;
		logic [15:0] addr;
		logic [15:0] sp;
		logic [7:0] op, b, v, lo, hi;
		logic fs, fz, fp, fc;
		logic running;
		int res;
		int steps;
		for (int i = 0; i < 8; i++)
			r[i] = 8'h00;
		pc = resetPc;
		sp = 16'h0000;
		{fs, fz, fp, fc} = 4'b0000;
		running = 1'b1;
		steps = 0;
		while (running && steps < 100000) begin
			op = refMem[pc];
			pc = pc + 16'd1;
			steps++;
			hl = {r[4], r[5]};
			lo = refMem[pc];
			hi = refMem[pc + 16'd1];
			addr = {hi, lo};
			if (op == 8'h76) begin
				running = 1'b0;
			end else if (op[7:6] == 2'b01) begin
				v = op[2:0] == 3'd6 ? refMem[hl] : r[op[2:0]];
				if (op[5:3] == 3'd6)
					refMem[hl] = v;
				else
					r[op[5:3]] = v;
			end else if (op[7:6] == 2'b00 && op[2:0] == 3'd6) begin
				pc = pc + 16'd1;
				if (op[5:3] == 3'd6)
					refMem[hl] = lo;
				else
					r[op[5:3]] = lo;
			end else if (op[7:6] == 2'b00 && op[3:0] == 4'd1) begin
				pc = pc + 16'd2;
				case (op[5:4])
					2'd0: {r[0], r[1]} = addr;
					2'd1: {r[2], r[3]} = addr;
					2'd2: {r[4], r[5]} = addr;
					default: sp = addr;
				endcase
			end else if (op == 8'h3A || op == 8'h32) begin
				pc = pc + 16'd2;
				if (op == 8'h3A)
					r[7] = refMem[addr];
				else
					refMem[addr] = r[7];
			end else if (op == 8'h2F) begin
				r[7] = ~r[7];
			end else if (op == 8'h37 || op == 8'h3F) begin
				fc = op == 8'h37 ? 1'b1 : !fc;
			end else if (op[7:6] == 2'b10 || (op[7:6] == 2'b11 && op[2:0] == 3'd6)) begin
				if (op[7:6] == 2'b10) begin
					b = op[2:0] == 3'd6 ? refMem[hl] : r[op[2:0]];
				end else begin
					b = lo;
					pc = pc + 16'd1;
				end
				case (op[5:3])
					3'd0: res = int'(r[7]) + int'(b);
					3'd1: res = int'(r[7]) + int'(b) + int'(fc);
					3'd2, 3'd7: res = int'(r[7]) - int'(b);
					3'd3: res = int'(r[7]) - int'(b) - int'(fc);
					3'd4: res = int'(r[7] & b);
					3'd5: res = int'(r[7] ^ b);
					default: res = int'(r[7] | b);
				endcase
				v = 8'(res);
				fc = res < 0 || res > 255; // Logic results never leave 0 to 255
				fs = v[7];
				fz = v == 8'h00;
				fp = evenParity(v);
				if (op[5:3] != 3'd7)
					r[7] = v;
			end else if (op == 8'hC3 || (op[7:6] == 2'b11 && op[2:0] == 3'd2)) begin
				pc = pc + 16'd2;
				if (op == 8'hC3 || conditionHolds(op[5:3], fs, fz, fp, fc))
					pc = addr;
			end
		end
		return !running;
	endfunction

	//**************************************************************************
	// Memory model with random wait states
	//**************************************************************************

	always @(negedge clk) begin
		if (!rst_n) begin
			pending = 1'b0;
			memDone = 1'b0;
		end else begin
			if (memDone) begin
				memDone = 1'b0;
				pending = 1'b0;
			end
			checkEqual(16'(mem.read & mem.write), 16'd0, "read and write strobes together");
			if (halted)
				checkEqual(16'(mem.read | mem.write), 16'd0, "strobe after HLT");
			if (mem.read || mem.write) begin
				if (!pending) begin
					pending = 1'b1;
					heldReq = mem;
					waitLeft = int'($urandom_range(3, 0));
				end else begin
					checkEqual(16'(mem.read), 16'(heldReq.read), "read strobe while waiting");
					checkEqual(16'(mem.write), 16'(heldReq.write), "write strobe while waiting");
					checkEqual(mem.addr, heldReq.addr, "address while waiting");
					if (mem.write)
						checkEqual(16'(mem.wdata), 16'(heldReq.wdata), "write data while waiting");
				end
				if (waitLeft == 0) begin
					if (mem.write)
						memory[mem.addr] = mem.wdata;
					else
						memRdata = memory[mem.addr];
					memDone = 1'b1;
				end else begin
					waitLeft = waitLeft - 1;
				end
			end
		end
	end

	initial begin
		logic refHalted;
		void'($urandom(randSeed));
		rst_n = 1'b0;
		memDone = 1'b0;
		memRdata = 8'h00;
		for (int a = 0; a < 65536; a++)
			memory[16'(a)] = fillByte(16'(a));
		buildProgram();
		for (int a = 0; a < 65536; a++)
			refMem[16'(a)] = memory[16'(a)];
		refHalted = runReference();
		checkEqual(16'(refHalted), 16'd1, "reference run reaching HLT");
		imageReady = 1'b1;

		repeat (4) @(negedge clk);
		checkEqual(16'(mem.read), 16'd1, "read strobe in reset");
		checkEqual(16'(mem.write), 16'd0, "write strobe in reset");
		checkEqual(mem.addr, resetPc, "fetch address in reset");
		checkEqual(16'(halted), 16'd0, "halted in reset");
		rst_n <= 1'b1;

		wait (halted === 1'b1);
		repeat (20) begin
			@(negedge clk);
			checkEqual(16'(halted), 16'd1, "halted after HLT");
		end
		for (int a = 0; a < 65536; a++)
			checkEqual(16'(memory[16'(a)]), 16'(refMem[16'(a)]),
				$sformatf("memory byte at %h", 16'(a)));
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		int timeoutNs;
		wait (imageReady);
		timeoutNs = numInstr * 8 * 4 * 10 + overheadNs;
		#(timeoutNs);
		$display("Watchdog timeout: the core did not finish its program within %0d ns",
			timeoutNs);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped by the watchdog");
	end

endmodule

/* filelist.f */
hw/cpuPkg.sv
hw/cpuAlu.sv
hw/cpuControl.sv
hw/cpuDatapath.sv
hw/cpuTop.sv
verif/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --top-module cpuTb -f filelist.f -Mdir obj_dir -o cpuSim \
	> "$LOG" 2>&1 \
	&& ./obj_dir/cpuSim >> "$LOG" 2>&1 \
	|| echo "TEST FAILED" >> "$LOG"
grep -q "TEST FAILED" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
echo "Simulation passed, see $LOG"
exit 0
